//--- prom_cmd_pkg.sv
// flash opcode set and per-opcode bit counts, imported by the command sequencer
package prom_cmd_pkg;

    localparam int op_w = 8;                    // opcode field width
    localparam int bits_w = 7;                  // width of send/recv bit counts

    localparam logic [op_w-1:0] op_wren      = 8'h06;
    localparam logic [op_w-1:0] op_wrdi      = 8'h04;
    localparam logic [op_w-1:0] op_rdid      = 8'h9f;
    localparam logic [op_w-1:0] op_rdsr      = 8'h05;
    localparam logic [op_w-1:0] op_wrsr      = 8'h01;
    localparam logic [op_w-1:0] op_read      = 8'h03;
    localparam logic [op_w-1:0] op_fast_read = 8'h0b;
    localparam logic [op_w-1:0] op_page_prog = 8'h02;  // only reaches flash as block stream
    localparam logic [op_w-1:0] op_se        = 8'hd8;
    localparam logic [op_w-1:0] op_be        = 8'hc7;
    localparam logic [op_w-1:0] op_dp        = 8'hb9;
    localparam logic [op_w-1:0] op_res       = 8'hab;

    typedef struct packed {
        logic              valid;               // opcode known
        logic [bits_w-1:0] send_bits;           // opcode + address + dummy bits
        logic [bits_w-1:0] recv_bits;           // reply bits, 0 if none
    } cmd_info_t;

    function automatic cmd_info_t cmd_lookup(input logic [op_w-1:0] op);
        cmd_info_t info;
        info = '0;                              // 00 and unknown opcodes stay invalid
        case (op)
            op_wren, op_wrdi, op_be, op_dp: info = '{1'b1, 7'd8, 7'd0};
            op_rdid:      info = '{1'b1, 7'd8, 7'd24};   // first 3 id bytes
            op_rdsr:      info = '{1'b1, 7'd8, 7'd8};
            op_wrsr:      info = '{1'b1, 7'd16, 7'd0};
            op_read:      info = '{1'b1, 7'd32, 7'd32};  // one quadlet back
            op_fast_read: info = '{1'b1, 7'd40, 7'd32};  // extra dummy byte
            op_se:        info = '{1'b1, 7'd32, 7'd0};
            op_res:       info = '{1'b1, 7'd32, 7'd8};   // old style id
            default:      info = '0;
        endcase
        return info;
    endfunction

endpackage

//--- prom_host_pkg.sv
// host side widths, block buffer size, status word layout and sequencer states
package prom_host_pkg;

    localparam int quad_w     = 32;             // host word
    localparam int blk_depth  = 66;             // quadlets held per block write
    localparam int idx_w      = 7;              // buffer index, wraps past 64
    localparam int blk_addr_w = 6;              // host block address

    // status word fields
    localparam int err_msb     = 31;
    localparam int err_lsb     = 16;
    localparam int err_w       = err_msb - err_lsb + 1;
    localparam int cs_bit      = 7;
    localparam int sclk_bit    = 6;
    localparam int miso_bit    = 5;
    localparam int mosi_bit    = 4;
    localparam int blk_wrt_bit = 3;
    localparam int state_msb   = 2;             // state occupies [state_msb:0]

    typedef enum logic [2:0] {
        st_idle          = 3'd0,
        st_chip_select   = 3'd1,
        st_write         = 3'd2,
        st_write_block   = 3'd3,
        st_read          = 3'd4,
        st_chip_deselect = 3'd5
    } seq_state_t;

endpackage

//--- spi_xfer_if.sv
// one SPI shift job handed from the sequencer to the serial engine
`timescale 1ns/10ps
interface spi_xfer_if #(
    parameter int quad_w = prom_host_pkg::quad_w,
    parameter int bits_w = prom_cmd_pkg::bits_w
);
    logic              start;                   // one cycle, latches the job
    logic [quad_w-1:0] tx_word;                 // msb goes out first
    logic [bits_w-1:0] send_bits;
    logic [bits_w-1:0] recv_bits;
    logic              load_next;               // reload tx_word at word end
    logic              busy;
    logic              done;                    // last bit of the job
    logic [quad_w-1:0] rx_word;                 // reply, right aligned

    modport master (
        output start, tx_word, send_bits, recv_bits, load_next,
        input  busy, done, rx_word
    );

    modport engine (
        input  start, tx_word, send_bits, recv_bits, load_next,
        output busy, done, rx_word
    );
endinterface

//--- prom_ctl_if.sv
// sequencer and buffer error path toward the result/status register block
`timescale 1ns/10ps
interface prom_ctl_if #(
    parameter int quad_w = prom_host_pkg::quad_w,
    parameter int err_w  = prom_host_pkg::err_w
);
    import prom_host_pkg::*;

    seq_state_t        state;
    logic              blk_wrt;                 // block write in progress
    logic              clear_result;            // cs falling
    logic              load_result;
    logic [quad_w-1:0] result_value;
    logic              err_load;                // bad block address seen
    logic [err_w-1:0]  err_value;

    modport seq (
        output state, blk_wrt, clear_result, load_result, result_value
    );

    modport regs (
        input state, blk_wrt, clear_result, load_result, result_value, err_load, err_value
    );
endinterface

//--- prom_spi_engine.sv
// serial engine, clocks out send bits then samples reply bits on a half rate sclk
`timescale 1ns/10ps
module prom_spi_engine #(
    parameter int quad_w = prom_host_pkg::quad_w
) (
    input  logic       clk,
    input  logic       reset,
    spi_xfer_if.engine xfer,
    output logic       sclk,
    output logic       mosi,
    input  logic       miso
);
    import prom_cmd_pkg::*;

    logic              active;
    logic              rx_phase;                // past the send bits
    logic              recv_none;               // job has no reply
    logic [bits_w-1:0] cnt;                     // half sclk periods, lsb is sclk
    logic [bits_w-1:0] send_last;               // 2*send_bits-1
    logic [bits_w-1:0] recv_last;               // 2*recv_bits-1
    logic [bits_w-1:0] end_cnt;
    logic [quad_w-1:0] tx_shift;
    logic [quad_w-1:0] rx_shift;

    assign sclk = cnt[0];                       // idles low, cnt parks at 0
    assign mosi = tx_shift[quad_w-1];

    always_comb begin
        end_cnt = rx_phase ? recv_last : send_last;
        xfer.busy = active;
        xfer.done = active && (cnt == end_cnt) && (rx_phase || recv_none);
        xfer.rx_word = rx_shift;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            active   <= 1'b0;
            rx_phase <= 1'b0;
            cnt      <= '0;
            tx_shift <= '0;                     // mosi low out of reset
        end else if (xfer.start) begin
            active    <= 1'b1;
            rx_phase  <= 1'b0;
            cnt       <= '0;
            tx_shift  <= xfer.tx_word;
            rx_shift  <= '0;                    // short replies end right aligned
            send_last <= (xfer.send_bits << 1) - bits_w'(1);
            recv_last <= (xfer.recv_bits << 1) - bits_w'(1);
            recv_none <= (xfer.recv_bits == '0);
        end else if (active) begin
            if (cnt[0])
                tx_shift <= tx_shift << 1;      // mosi moves on falling sclk
            if (rx_phase && !cnt[0])
                rx_shift <= {rx_shift[quad_w-2:0], miso};  // sample with rising sclk
            if (cnt == end_cnt) begin
                cnt <= '0;
                if (xfer.load_next)
                    tx_shift <= xfer.tx_word;   // next block quadlet, no gap
                else if (rx_phase || recv_none) begin
                    active   <= 1'b0;
                    rx_phase <= 1'b0;
                    tx_shift <= '0;
                end else
                    rx_phase <= 1'b1;
            end else
                cnt <= cnt + bits_w'(1);
        end
    end

endmodule

//--- prom_block_buffer.sv
// quadlet store filled by host block writes, drained by the sequencer, host readable
`timescale 1ns/10ps
module prom_block_buffer #(
    parameter int quad_w     = prom_host_pkg::quad_w,
    parameter int blk_depth  = prom_host_pkg::blk_depth,
    parameter int idx_w      = prom_host_pkg::idx_w,
    parameter int blk_addr_w = prom_host_pkg::blk_addr_w,
    parameter int err_w      = prom_host_pkg::err_w
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  blk_start,
    input  logic                  blk_wen,
    input  logic [blk_addr_w-1:0] blk_addr,
    input  logic [quad_w-1:0]     wdata,
    input  logic [idx_w-1:0]      rd_index,
    output logic [quad_w-1:0]     rd_word,
    input  logic                  host_rd_en,
    output logic [quad_w-1:0]     rdata,
    output logic [idx_w-1:0]      wr_index,
    output logic                  err_load,
    output logic [err_w-1:0]      err_value
);
    logic [quad_w-1:0] mem [blk_depth];
    logic              addr_ok;

    assign addr_ok = (blk_addr == wr_index[blk_addr_w-1:0]);  // low bits, index may wrap
    assign rd_word = mem[rd_index];             // feeds the engine directly

    always_ff @(posedge clk) begin
        if (!reset) begin
            wr_index <= '0;
            err_load <= 1'b0;
        end else begin
            err_load <= blk_wen && !blk_start && !addr_ok;
            if (blk_start)
                wr_index <= '0;
            else if (blk_wen && addr_ok)
                wr_index <= wr_index + idx_w'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (blk_wen && !blk_start && addr_ok)
            mem[wr_index] <= wdata;
        if (blk_wen && !addr_ok)
            err_value <= err_w'({blk_addr, 1'b0, wr_index});  // bad addr, expected index
        if (host_rd_en)
            rdata <= mem[blk_addr];
    end

endmodule

//--- prom_sequencer.sv
// opcode decode and chip select/write/read/deselect FSM, plus block write streaming
`timescale 1ns/10ps
module prom_sequencer #(
    parameter int quad_w = prom_host_pkg::quad_w,
    parameter int idx_w  = prom_host_pkg::idx_w
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [quad_w-1:0] cmd,
    input  logic              reg_wen,
    input  logic              blk_start,
    input  logic              blk_end,
    input  logic [idx_w-1:0]  wr_index,
    output logic [idx_w-1:0]  rd_index,
    input  logic [quad_w-1:0] rd_word,
    spi_xfer_if.master        xfer,
    prom_ctl_if.seq           ctl,
    output logic              cs
);
    import prom_host_pkg::*;
    import prom_cmd_pkg::*;

    seq_state_t        state;
    cmd_info_t         info;                    // decode of the incoming opcode
    logic [quad_w-1:0] cmd_q;
    logic [bits_w-1:0] send_q;
    logic [bits_w-1:0] recv_q;
    logic [bits_w-1:0] half_cnt;                // write half periods left
    logic              blk_wrt;
    logic              blk_open;                // block start accepted
    logic              blk_go;                  // buffer has data, begin stream
    logic              caught_up;

    always_comb begin
        info      = cmd_lookup(cmd[quad_w-1 -: op_w]);
        caught_up = (rd_index == wr_index);
        blk_open  = (state == st_idle) && !reg_wen && blk_start && !blk_wrt;
        blk_go    = (state == st_idle) && !reg_wen && blk_wrt && (wr_index != '0)
                    && !xfer.busy;
        xfer.start     = (state == st_chip_select) || blk_go;
        xfer.tx_word   = (state == st_chip_select) ? cmd_q : rd_word;
        xfer.send_bits = send_q;
        xfer.recv_bits = recv_q;
        xfer.load_next = (state == st_write_block) && xfer.done && !caught_up;
        ctl.state        = state;
        ctl.blk_wrt      = blk_wrt;
        ctl.clear_result = (state == st_chip_select) || blk_open;
        ctl.load_result  = xfer.done && ((state != st_write_block) || caught_up);
        ctl.result_value = (state == st_write_block) ? quad_w'(rd_index) : xfer.rx_word;
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state    <= st_idle;
            cs       <= 1'b1;
            blk_wrt  <= 1'b0;
            rd_index <= '0;
        end else begin
            if (blk_end)
                blk_wrt <= 1'b0;                // host side closed, stream may go on
            case (state)
                st_idle: begin
                    if (reg_wen) begin
                        blk_wrt <= 1'b0;
                        cmd_q   <= cmd;
                        send_q  <= info.send_bits;
                        recv_q  <= info.recv_bits;
                        if (info.valid)
                            state <= st_chip_select;
                    end else if (blk_open) begin
                        blk_wrt  <= 1'b1;
                        cs       <= 1'b0;       // hold chip until buffer drains
                        rd_index <= '0;         // stream begins at word 0
                        send_q   <= bits_w'(quad_w);
                        recv_q   <= '0;
                    end else if (blk_go) begin
                        rd_index <= idx_w'(1);  // word 0 goes out with start
                        state    <= st_write_block;
                    end
                end
                st_chip_select: begin
                    cs       <= 1'b0;
                    half_cnt <= send_q << 1;
                    state    <= st_write;
                end
                st_write: begin
                    half_cnt <= half_cnt - bits_w'(1);
                    if (xfer.done) begin        // nothing to read back
                        cs    <= 1'b1;
                        state <= st_chip_deselect;
                    end else if (half_cnt == bits_w'(1))
                        state <= st_read;
                end
                st_read: begin
                    if (xfer.done) begin
                        cs    <= 1'b1;
                        state <= st_chip_deselect;
                    end
                end
                st_write_block: begin
                    if (xfer.done) begin
                        if (caught_up) begin    // reader met writer at word end
                            cs      <= 1'b1;
                            blk_wrt <= 1'b0;
                            state   <= st_chip_deselect;
                        end else
                            rd_index <= rd_index + idx_w'(1);
                    end
                end
                st_chip_deselect: state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- prom_host_regs.sv
// result register, block error latch and status word seen by the host
`timescale 1ns/10ps
module prom_host_regs #(
    parameter int quad_w = prom_host_pkg::quad_w,
    parameter int err_w  = prom_host_pkg::err_w
) (
    input  logic              clk,
    input  logic              reset,
    prom_ctl_if.regs          ctl,
    input  logic              sclk,
    input  logic              mosi,
    input  logic              miso,
    input  logic              cs,
    output logic [quad_w-1:0] result,
    output logic [quad_w-1:0] status
);
    import prom_host_pkg::*;

    logic [err_w-1:0] err_field;                // first bad block address
    logic             err_clear;

    // block start is the only clear seen while idle
    assign err_clear = ctl.clear_result && (ctl.state == st_idle);

    always_ff @(posedge clk) begin
        if (!reset) begin
            result    <= '0;
            err_field <= '0;
        end else begin
            if (ctl.clear_result)
                result <= '0;
            else if (ctl.load_result)
                result <= ctl.result_value;     // reply bits or quadlet count
            if (err_clear)
                err_field <= '0;
            else if (ctl.err_load)
                err_field <= ctl.err_value;
        end
    end

    always_comb begin
        status                   = '0;
        status[err_msb:err_lsb]  = err_field;
        status[cs_bit]           = cs;          // live pins
        status[sclk_bit]         = sclk;
        status[miso_bit]         = miso;
        status[mosi_bit]         = mosi;
        status[blk_wrt_bit]      = ctl.blk_wrt;
        status[state_msb:0]      = ctl.state;
    end

endmodule

//--- prom_programmer.sv
// top level of the flash programmer, host strobes in and SPI flash pins out
`timescale 1ns/10ps
module prom_programmer #(
    parameter int quad_w     = prom_host_pkg::quad_w,
    parameter int blk_depth  = prom_host_pkg::blk_depth,
    parameter int idx_w      = prom_host_pkg::idx_w,
    parameter int blk_addr_w = prom_host_pkg::blk_addr_w
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [quad_w-1:0]     prom_cmd,
    input  logic                  prom_reg_wen,
    input  logic                  prom_blk_start,
    input  logic                  prom_blk_wen,
    input  logic [blk_addr_w-1:0] prom_blk_addr,
    input  logic                  prom_blk_end,
    input  logic                  prom_blk_enable,
    output logic [quad_w-1:0]     prom_status,
    output logic [quad_w-1:0]     prom_result,
    output logic [quad_w-1:0]     prom_rdata,
    output logic                  prom_cs,
    output logic                  prom_sclk,
    output logic                  prom_mosi,
    input  logic                  prom_miso
);
    logic [idx_w-1:0]  wr_index;
    logic [idx_w-1:0]  rd_index;
    logic [quad_w-1:0] rd_word;
    logic              host_rd_en;

    // buffer read back only when no other host strobe is up
    assign host_rd_en = prom_blk_enable && !prom_reg_wen && !prom_blk_start
                        && !prom_blk_wen && !prom_blk_end;

    spi_xfer_if #(.quad_w(quad_w)) xfer ();
    prom_ctl_if #(.quad_w(quad_w)) ctl ();

    prom_block_buffer #(.quad_w(quad_w), .blk_depth(blk_depth), .idx_w(idx_w),
                        .blk_addr_w(blk_addr_w)) i_block_buffer (
        .clk(clk), .reset(reset), .blk_start(prom_blk_start), .blk_wen(prom_blk_wen),
        .blk_addr(prom_blk_addr), .wdata(prom_cmd), .rd_index(rd_index), .rd_word(rd_word),
        .host_rd_en(host_rd_en), .rdata(prom_rdata), .wr_index(wr_index),
        .err_load(ctl.err_load), .err_value(ctl.err_value)
    );

    prom_sequencer #(.quad_w(quad_w), .idx_w(idx_w)) i_sequencer (
        .clk(clk), .reset(reset), .cmd(prom_cmd), .reg_wen(prom_reg_wen),
        .blk_start(prom_blk_start), .blk_end(prom_blk_end), .wr_index(wr_index),
        .rd_index(rd_index), .rd_word(rd_word), .xfer(xfer.master), .ctl(ctl.seq),
        .cs(prom_cs)
    );

    prom_spi_engine #(.quad_w(quad_w)) i_spi_engine (
        .clk(clk), .reset(reset), .xfer(xfer.engine), .sclk(prom_sclk), .mosi(prom_mosi),
        .miso(prom_miso)
    );

    prom_host_regs #(.quad_w(quad_w)) i_host_regs (
        .clk(clk), .reset(reset), .ctl(ctl.regs), .sclk(prom_sclk), .mosi(prom_mosi),
        .miso(prom_miso), .cs(prom_cs), .result(prom_result), .status(prom_status)
    );

endmodule

//--- spi_flash_model.sv
// behavioral serial flash for the testbench, answers id, status, wren/wrdi, program, erase, read
`timescale 1ns/10ps
module spi_flash_model (
    input  logic cs,
    input  logic sclk,
    input  logic mosi,
    output logic miso
);
    logic [7:0]  mem [4096];                    // low 12 address bits only
    logic [31:0] sh;                            // opcode + address as shifted in
    logic [7:0]  op;
    logic [23:0] addr;
    logic        wel;                           // write enable latch
    int          cnt;                           // bits seen since cs fell

    function automatic logic reply_bit(input int p);
        logic [23:0] id;
        logic [7:0]  sr;
        logic [7:0]  b;
        int          q;
        id = 24'h202015;
        sr = {6'b0, wel, 1'b0};
        q  = (op == 8'h0b) ? p - 40 : p - 32;   // fast read has a dummy byte
        case (op)
            8'h9f: return (p >= 8 && p < 32) ? id[31-p] : 1'b0;
            8'h05: return (p >= 8 && p < 16) ? sr[15-p] : 1'b0;
            8'hab: return (p >= 32 && p < 40) ? 8'h14 >> (39 - p) & 1'b1 : 1'b0;
            8'h03, 8'h0b: begin
                if (q < 0)
                    return 1'b0;
                b = mem[12'(addr + 24'(q / 8))];
                return b[7 - q % 8];
            end
            default: return 1'b0;
        endcase
    endfunction

    initial begin
        miso = 1'b0;
        wel  = 1'b0;
        cnt  = 0;
        op   = '0;
        for (int i = 0; i < 4096; i++)
            mem[i] = 8'(i ^ (i >> 4));          // pattern over all address bits
    end

    always @(posedge sclk) begin
        if (!cs) begin
            sh  = {sh[30:0], mosi};
            cnt = cnt + 1;
            if (cnt == 8)
                op = sh[7:0];
            if (cnt == 32)
                addr = sh[23:0];
            if (op == 8'h02 && wel && cnt >= 40 && cnt % 8 == 0)
                mem[12'(addr + 24'((cnt - 40) / 8))] = sh[7:0];  // page program byte
        end
    end

    always @(negedge sclk) begin
        if (!cs)
            miso <= reply_bit(cnt);             // next reply bit out on falling sclk
    end

    always @(posedge cs) begin
        if (cnt == 8 && op == 8'h06)
            wel = 1'b1;
        if (cnt == 8 && op == 8'h04)
            wel = 1'b0;
        if (op == 8'hd8 && cnt == 32 && wel) begin
            for (int i = 0; i < 4096; i++)
                mem[i] = 8'hff;                 // whole model fits in one sector
            wel = 1'b0;
        end
        if (op == 8'h02 && cnt >= 32)
            wel = 1'b0;
        cnt = 0;
        op  = '0;
    end

endmodule

//--- tb_prom_programmer.sv
// directed testbench for the flash programmer, run with the flash model on the spi pins
`timescale 1ns/10ps
module tb_prom_programmer;
    localparam int max_cycles = 5000;           // all tests need well under half of this

    logic        clk;
    logic        reset;
    logic [31:0] prom_cmd;
    logic        prom_reg_wen;
    logic        prom_blk_start;
    logic        prom_blk_wen;
    logic [5:0]  prom_blk_addr;
    logic        prom_blk_end;
    logic        prom_blk_enable;
    logic [31:0] prom_status;
    logic [31:0] prom_result;
    logic [31:0] prom_rdata;
    logic        prom_cs;
    logic        prom_sclk;
    logic        prom_mosi;
    logic        prom_miso;

    integer      seed = 32'hdefc;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          test_errs = 0;
    int          tests = 0;
    logic [5:0]  blk_addrs [16];                 // host addresses of one block write
    logic [31:0] blk_words [16];

    prom_programmer i_prom_programmer (
        .clk(clk), .reset(reset), .prom_cmd(prom_cmd), .prom_reg_wen(prom_reg_wen),
        .prom_blk_start(prom_blk_start), .prom_blk_wen(prom_blk_wen),
        .prom_blk_addr(prom_blk_addr), .prom_blk_end(prom_blk_end),
        .prom_blk_enable(prom_blk_enable), .prom_status(prom_status),
        .prom_result(prom_result), .prom_rdata(prom_rdata), .prom_cs(prom_cs),
        .prom_sclk(prom_sclk), .prom_mosi(prom_mosi), .prom_miso(prom_miso)
    );

    spi_flash_model i_flash (.cs(prom_cs), .sclk(prom_sclk), .mosi(prom_mosi), .miso(prom_miso));

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("run stopped, a test did not finish within %0d cycles", max_cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Error: %s = %h, expected %h", name, got, exp);
            test_errs++;
        end
    endtask

    task automatic wait_idle();
        do
            @(negedge clk);
        while (prom_status[2:0] != 3'd0 || !prom_cs);  // stable between edges
    endtask

    task automatic send_cmd(input logic [31:0] word);
        @(negedge clk);
        prom_cmd     = word;
        prom_reg_wen = 1'b1;
        @(negedge clk);
        prom_reg_wen = 1'b0;
        wait_idle();
    endtask

    // host side of a block write, n quadlets from blk_addrs/blk_words
    task automatic write_block(input int n);
        @(negedge clk);
        prom_blk_start = 1'b1;
        @(negedge clk);
        prom_blk_start = 1'b0;
        for (int i = 0; i < n; i++) begin
            prom_blk_wen  = 1'b1;
            prom_blk_addr = blk_addrs[i];
            prom_cmd      = blk_words[i];
            @(negedge clk);
        end
        prom_blk_wen = 1'b0;
        prom_blk_end = 1'b1;
        @(negedge clk);
        prom_blk_end = 1'b0;
        wait_idle();
    endtask

    task automatic finish_test(input string name);
        tests++;
        errors += test_errs;
        if (test_errs == 0)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, test_errs);
        test_errs = 0;
    endtask

    task automatic test_reset_and_nop();
        check_val("prom_cs", 32'(prom_cs), 32'h1);
        check_val("prom_sclk", 32'(prom_sclk), 32'h0);
        check_val("prom_mosi", 32'(prom_mosi), 32'h0);
        check_val("state", 32'(prom_status[2:0]), 32'h0);
        check_val("blk_wrt", 32'(prom_status[3]), 32'h0);
        check_val("status pins", 32'(prom_status[7:4]), 32'h8);  // cs high, rest low
        check_val("error field", 32'(prom_status[31:16]), 32'h0);
        check_val("prom_result", prom_result, 32'h0);
        for (int k = 0; k < 2; k++) begin
            @(negedge clk);
            prom_cmd     = (k == 0) ? 32'h0 : 32'h5a000000;  // 00 then unknown
            prom_reg_wen = 1'b1;
            for (int c = 0; c < 10; c++) begin
                @(negedge clk);
                prom_reg_wen = 1'b0;
                checks++;
                assert (prom_cs === 1'b1) else begin
                    $display("chip select went low for an opcode that does nothing");
                    test_errs++;
                end
            end
        end
        finish_test("reset and no-op");
    endtask

    task automatic test_read_id();
        send_cmd(32'h9f000000);
        check_val("prom_result", prom_result, 32'h00202015);
        send_cmd(32'hab000000);
        check_val("prom_result", prom_result, 32'h00000014);
        finish_test("read id");
    endtask

    task automatic test_write_enable();
        send_cmd(32'h06000000);
        send_cmd(32'h05000000);
        check_val("wel", 32'(prom_result[1]), 32'h1);
        send_cmd(32'h04000000);
        send_cmd(32'h05000000);
        check_val("wel", 32'(prom_result[1]), 32'h0);
        finish_test("write enable");
    endtask

    task automatic test_block_write();
        int n;
        n = 4;
        blk_addrs[0] = 6'd0;
        blk_words[0] = 32'h02000100;             // page program at 0x100
        for (int i = 1; i <= n; i++) begin
            blk_addrs[i] = 6'(i);
            blk_words[i] = $random(seed);
        end
        send_cmd(32'h06000000);
        write_block(n + 1);
        check_val("prom_result", prom_result, 32'(n + 1));
        send_cmd(32'h03000100);
        check_val("prom_result", prom_result, blk_words[1]);
        for (int i = 0; i <= n; i++) begin
            @(negedge clk);
            prom_blk_enable = 1'b1;
            prom_blk_addr   = 6'(i);
            @(negedge clk);
            prom_blk_enable = 1'b0;
            check_val("prom_rdata", prom_rdata, blk_words[i]);
        end
        finish_test("block write");
    endtask

    task automatic test_block_bad_addr();
        int          expect_idx;
        int          accepted;
        logic [15:0] expect_err;
        blk_addrs[0] = 6'd0;
        blk_addrs[1] = 6'd1;
        blk_addrs[2] = 6'd5;                     // out of order
        blk_addrs[3] = 6'd2;
        blk_words[0] = 32'h02000200;
        for (int i = 1; i < 4; i++)
            blk_words[i] = $random(seed);
        expect_idx = 0;
        expect_err = '0;
        for (int i = 0; i < 4; i++) begin
            if (int'(blk_addrs[i]) == expect_idx)
                expect_idx++;
            else
                expect_err = 16'((int'(blk_addrs[i]) << 8) | expect_idx);
        end
        accepted = expect_idx;
        send_cmd(32'h06000000);
        write_block(4);
        check_val("error field", 32'(prom_status[31:16]), 32'(expect_err));
        check_val("prom_result", prom_result, 32'(accepted));
        send_cmd(32'h03000200);
        check_val("prom_result", prom_result, blk_words[1]);  // first accepted data quadlet
        finish_test("block bad address");
    endtask

    task automatic test_sector_erase();
        send_cmd(32'h06000000);
        send_cmd(32'hd8000100);
        send_cmd(32'h03000100);
        check_val("prom_result", prom_result, 32'hffffffff);
        finish_test("sector erase");
    endtask

    initial begin
        clk             = 1'b0;
        reset           = 1'b0;                  // held low for 5 cycles
        prom_cmd        = '0;
        prom_reg_wen    = 1'b0;
        prom_blk_start  = 1'b0;
        prom_blk_wen    = 1'b0;
        prom_blk_addr   = '0;
        prom_blk_end    = 1'b0;
        prom_blk_enable = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);
        test_reset_and_nop();
        test_read_id();
        test_write_enable();
        test_block_write();
        test_block_bad_addr();
        test_sector_erase();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

//--- prom_programmer.f
prom_cmd_pkg.sv
prom_host_pkg.sv
spi_xfer_if.sv
prom_ctl_if.sv
prom_spi_engine.sv
prom_block_buffer.sv
prom_sequencer.sv
prom_host_regs.sv
prom_programmer.sv
spi_flash_model.sv
tb_prom_programmer.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP       = tb_prom_programmer
RTL_TOP   = prom_programmer
FILELIST  = prom_programmer.f
LOG       = sim.log
BIN       = sim_bin

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(BIN)
	./obj_dir/$(BIN) | tee $(LOG)
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
